/* design/sine_table.hex */
// sine table, one signed 12-bit two's complement sample per line, address 0 to 63
000
0C9
18F
252
30F
3C5
471
513
5A7
62E
6A6
70D
763
7A7
7D8
7F5
7FF
7F5
7D8
7A7
763
70D
6A6
62E
5A7
513
471
3C5
30F
252
18F
0C9
000
F37
E71
DAE
CF1
C3B
B8F
AED
A59
9D2
95A
8F3
89D
859
828
80B
801
80B
828
859
89D
8F3
95A
9D2
A59
AED
B8F
C3B
CF1
DAE
E71
F37

/* files.f */
design/dds_pkg.sv
design/dds_waveform_gen.sv
design/lfsr_symbol_gen.sv
design/modulation_mixer.sv
design/dds_lfsr_top.sv
testbench/tb_dds_lfsr_top.sv

/* Bender.yml */
package:
  name: dds_lfsr

sources:
  - design/dds_pkg.sv
  - design/dds_waveform_gen.sv
  - design/lfsr_symbol_gen.sv
  - design/modulation_mixer.sv
  - design/dds_lfsr_top.sv
  - target: simulation
    files:
      - testbench/tb_dds_lfsr_top.sv

/* testbench/tb_dds_lfsr_top.sv */
module tb_dds_lfsr_top;

   timeunit 1ns;
   timeprecision 1ps;

   localparam int TICK_DIVIDE    = 16;
   localparam int CLK_HALF       = 20;   // 40 ns period
   localparam int DRIVE_DELAY    = 2;
   localparam int RESET_CYCLES   = 16;
   localparam int WAVE_CYCLES    = 300;
   localparam int LFSR_PERIOD    = 31 * TICK_DIVIDE;
   localparam int LFSR_CYCLES    = LFSR_PERIOD + 32;
   localparam int SEGMENT_CYCLES = 100;
   localparam int MIX_SEGMENTS   = 6;
   localparam int FSK_SEGMENTS   = 5;
   localparam int CYCLE_LIMIT    = RESET_CYCLES + 4 * WAVE_CYCLES + LFSR_CYCLES
                                   + (MIX_SEGMENTS + FSK_SEGMENTS + 1) * SEGMENT_CYCLES + 200;
   localparam string TABLE_FILE  = "design/sine_table.hex";

   logic               CLK_25MHZ;
   logic               reset_from_key;
   dds_pkg::phase_t    tuning_word;
   dds_pkg::wave_sel_e wave_sel;
   dds_pkg::mod_sel_e  mod_sel;
   dds_pkg::sample_t   wave_out;
   dds_pkg::sample_t   mod_out;
   logic               symbol;

   // reference model state
   dds_pkg::sample_t   sine_ref [0:dds_pkg::TABLE_DEPTH-1];
   dds_pkg::phase_t    ref_phase;
   dds_pkg::wave_set_t ref_waves;
   int                 ref_count;
   logic [4:0]         ref_lfsr;
   dds_pkg::sample_t   exp_wave;
   dds_pkg::sample_t   exp_mod;

   integer      seed;
   logic [31:0] rnd;
   bit          check_on;
   int          cycle_count;
   int          error_count;
   int          errors_at_start;
   int          tests_passed;
   int          tests_failed;
   logic        sym_hist [$];

   dds_lfsr_top #(
      .TICK_DIVIDE (TICK_DIVIDE)
   ) DUT (
      .CLK_25MHZ      (CLK_25MHZ),
      .reset_from_key (reset_from_key),
      .tuning_word    (tuning_word),
      .wave_sel       (wave_sel),
      .mod_sel        (mod_sel),
      .wave_out       (wave_out),
      .mod_out        (mod_out),
      .symbol         (symbol)
   );

   initial
   begin
      CLK_25MHZ = 1'b0;
      forever #(CLK_HALF) CLK_25MHZ = ~CLK_25MHZ;
   end

   ////////////////////
   // reference functions
   ////////////////////

   // samples the generator should hold for a given phase
   function automatic dds_pkg::wave_set_t waves_for_phase(input dds_pkg::phase_t p);
      dds_pkg::wave_set_t w;
      logic [5:0] addr;
      addr     = p[31:26];
      w.sine   = sine_ref[addr];
      w.cosine = sine_ref[6'(addr + dds_pkg::QUARTER_OFFSET)];
      w.saw    = p[31:20];
      w.square = p[31] ? dds_pkg::sample_t'(-dds_pkg::SQUARE_HIGH) : dds_pkg::SQUARE_HIGH;
      return w;
   endfunction

   function automatic dds_pkg::sample_t pick_wave(input dds_pkg::wave_set_t w,
                                                 input dds_pkg::wave_sel_e sel);
      case (sel)
         dds_pkg::WAVE_SINE:   return w.sine;
         dds_pkg::WAVE_COSINE: return w.cosine;
         dds_pkg::WAVE_SAW:    return w.saw;
         default:              return w.square;
      endcase
   endfunction

   function automatic dds_pkg::sample_t modulate(input dds_pkg::wave_set_t w, input logic sym,
                                                input dds_pkg::mod_sel_e sel);
      case (sel)
         dds_pkg::MOD_ASK:  return sym ? w.sine : '0;
         dds_pkg::MOD_FSK:  return w.sine;
         dds_pkg::MOD_BPSK: return sym ? dds_pkg::sample_t'(-w.cosine) : w.cosine;
         default:           return sym ? '0 : dds_pkg::LFSR_LOW_LEVEL;
      endcase
   endfunction

   // model registers, same edges as the DUT
   always @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
      begin
         ref_phase = '0;
         ref_waves = '0;
         ref_count = 0;
         ref_lfsr  = dds_pkg::LFSR_SEED;
         exp_wave  = '0;
         exp_mod   = '0;
      end
      else
      begin
         exp_wave  = pick_wave(ref_waves, wave_sel);            // second stage
         exp_mod   = modulate(ref_waves, ref_lfsr[0], mod_sel);
         ref_waves = waves_for_phase(ref_phase);                // first stage
         ref_phase = ref_phase + ((mod_sel == dds_pkg::MOD_FSK) ? tuning_word
                                                                : dds_pkg::DEFAULT_TUNING);
         if (ref_count == TICK_DIVIDE - 1)
         begin
            ref_count = 0;
            ref_lfsr  = {ref_lfsr[0] ^ ref_lfsr[2], ref_lfsr[4:1]};
         end
         else
         begin
            ref_count = ref_count + 1;
         end
      end
   end

   ////////////////////
   // comparing process
   ////////////////////

   always @(negedge CLK_25MHZ)
   begin
      if (check_on)
      begin
         if (wave_out !== exp_wave)
         begin
            error_count++;
            $display("[ERROR] wave_out expected %h actual %h at cycle %0d",
                     exp_wave, wave_out, cycle_count);
         end
         if (mod_out !== exp_mod)
         begin
            error_count++;
            $display("[ERROR] mod_out expected %h actual %h at cycle %0d",
                     exp_mod, mod_out, cycle_count);
         end
         if (symbol !== ref_lfsr[0])
         begin
            error_count++;
            $display("[ERROR] symbol expected %h actual %h at cycle %0d",
                     ref_lfsr[0], symbol, cycle_count);
         end
      end
   end

   // watchdog
   always @(posedge CLK_25MHZ)
   begin
      cycle_count++;
      if (cycle_count >= CYCLE_LIMIT)
      begin
         $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
         $display("Regression failed");
         $finish;
      end
   end

   task automatic next_cycle();
      @(posedge CLK_25MHZ);
      #(DRIVE_DELAY);
   endtask

   task automatic finish_test(input string name);
      next_cycle();   // lets the last compare land in this test
      if (error_count == errors_at_start)
      begin
         tests_passed++;
         $display("test %-10s ok", name);
      end
      else
      begin
         tests_failed++;
         $display("test %-10s FAILED with %0d errors", name, error_count - errors_at_start);
      end
      errors_at_start = error_count;
   endtask

   ////////////////////
   // stimulus
   ////////////////////

   initial
   begin
      int   i;
      int   seg;
      int   ones;
      int   sym_changes;
      logic prev_sym;
      seed            = 32'h8778;
      reset_from_key  = 1'b1;
      tuning_word     = '0;
      wave_sel        = dds_pkg::WAVE_SINE;
      mod_sel         = dds_pkg::MOD_ASK;
      check_on        = 1'b0;
      cycle_count     = 0;
      error_count     = 0;
      errors_at_start = 0;
      tests_passed    = 0;
      tests_failed    = 0;
      $readmemh(TABLE_FILE, sine_ref);

      // reset values held through the whole reset
      for (i = 0; i < RESET_CYCLES; i++)
      begin
         next_cycle();
         check_on = 1'b1;
         if (wave_out !== '0)
         begin
            error_count++;
            $display("[ERROR] wave_out expected %h actual %h during reset", 12'h000, wave_out);
         end
         if (mod_out !== '0)
         begin
            error_count++;
            $display("[ERROR] mod_out expected %h actual %h during reset", 12'h000, mod_out);
         end
         if (symbol !== 1'b1)
         begin
            error_count++;
            $display("[ERROR] symbol expected %h actual %h during reset", 1'b1, symbol);
         end
      end
      reset_from_key = 1'b0;
      finish_test("reset");

      // every waveform at default tuning
      for (i = 0; i < 4; i++)
      begin
         wave_sel = dds_pkg::wave_sel_e'(i[1:0]);
         repeat (WAVE_CYCLES) next_cycle();
      end
      finish_test("waveforms");

      // symbol stream and raw LFSR level
      mod_sel  = dds_pkg::MOD_LFSR;
      prev_sym = ref_lfsr[0];
      sym_hist.delete();
      for (i = 0; i < LFSR_CYCLES; i++)
      begin
         next_cycle();
         if (mod_out !== (prev_sym ? 12'h000 : 12'h800))
         begin
            error_count++;
            $display("[ERROR] mod_out expected %h actual %h for symbol %h",
                     prev_sym ? 12'h000 : 12'h800, mod_out, prev_sym);
         end
         prev_sym = ref_lfsr[0];   // model symbol seen at the next edge
         sym_hist.push_back(symbol);
      end
      ones = 0;
      for (i = 0; i < LFSR_PERIOD; i++)
      begin
         ones += sym_hist[i];
         if (i + LFSR_PERIOD < sym_hist.size() && sym_hist[i] !== sym_hist[i + LFSR_PERIOD])
         begin
            error_count++;
            $display("symbol stream does not repeat after 31 ticks at sample %0d", i);
         end
      end
      if (ones != 16 * TICK_DIVIDE)
      begin
         error_count++;
         $display("symbol stream is not a full 31-state sequence, %0d ones seen", ones);
      end
      finish_test("lfsr");

      // ASK and BPSK over several symbol changes
      sym_changes = 0;
      prev_sym    = symbol;
      for (seg = 0; seg < MIX_SEGMENTS; seg++)
      begin
         rnd      = $random(seed);
         wave_sel = dds_pkg::wave_sel_e'(rnd[1:0]);
         mod_sel  = seg[0] ? dds_pkg::MOD_BPSK : dds_pkg::MOD_ASK;
         for (i = 0; i < SEGMENT_CYCLES; i++)
         begin
            next_cycle();
            if (symbol !== prev_sym)
            begin
               sym_changes++;
            end
            prev_sym = symbol;
         end
      end
      if (sym_changes < 4)
      begin
         error_count++;
         $display("symbol changed only %0d times during the ASK and BPSK run", sym_changes);
      end
      finish_test("ask_bpsk");

      // FSK with random tuning, then back to default step
      mod_sel = dds_pkg::MOD_FSK;
      for (seg = 0; seg < FSK_SEGMENTS; seg++)
      begin
         tuning_word = $random(seed);
         rnd         = $random(seed);
         wave_sel    = dds_pkg::wave_sel_e'(rnd[1:0]);
         repeat (SEGMENT_CYCLES) next_cycle();
      end
      mod_sel  = dds_pkg::MOD_ASK;   // tuning_word left at its last value
      wave_sel = dds_pkg::WAVE_SINE;
      repeat (SEGMENT_CYCLES) next_cycle();
      finish_test("fsk");

      $display("tests passed %0d failed %0d, errors %0d", tests_passed, tests_failed,
               error_count);
      if (tests_failed == 0 && error_count == 0)
      begin
         $display("Regression passed");
      end
      else
      begin
         $display("Regression failed");
      end
      $finish;
   end

endmodule

/* design/dds_lfsr_top.sv */
module dds_lfsr_top #(
   parameter int TICK_DIVIDE = 25_000_000   // one symbol step per second at 25 MHz
) (
   input  logic               CLK_25MHZ,
   input  logic               reset_from_key,
   input  dds_pkg::phase_t    tuning_word,   // used in FSK mode only
   input  dds_pkg::wave_sel_e wave_sel,
   input  dds_pkg::mod_sel_e  mod_sel,
   output dds_pkg::sample_t   wave_out,
   output dds_pkg::sample_t   mod_out,
   output logic               symbol
);

   dds_pkg::phase_t active_tuning;
   dds_pkg::wave_set_t waves;

   ////////////////////
   // tuning word choice
   ////////////////////

   // only FSK moves the DDS frequency
   assign active_tuning = (mod_sel == dds_pkg::MOD_FSK) ? tuning_word
                                                        : dds_pkg::DEFAULT_TUNING;

   ////////////////////
   // generators
   ////////////////////

   dds_waveform_gen u_waveform_gen (
      .CLK_25MHZ      (CLK_25MHZ),
      .reset_from_key (reset_from_key),
      .tuning         (active_tuning),
      .waves          (waves)              // sine, cosine, saw, square
   );

   // slow random symbol stream
   lfsr_symbol_gen #(
      .TICK_DIVIDE (TICK_DIVIDE)
   ) u_symbol_gen (
      .CLK_25MHZ      (CLK_25MHZ),
      .reset_from_key (reset_from_key),
      .symbol         (symbol)
   );

   ////////////////////
   // mixer
   ////////////////////

   modulation_mixer u_mixer (
      .CLK_25MHZ      (CLK_25MHZ),
      .reset_from_key (reset_from_key),
      .waves          (waves),
      .symbol         (symbol),
      .wave_sel       (wave_sel),
      .mod_sel        (mod_sel),
      .wave_out       (wave_out),          // registered selection
      .mod_out        (mod_out)
   );

endmodule

/* design/modulation_mixer.sv */
module modulation_mixer (
   input  logic               CLK_25MHZ,
   input  logic               reset_from_key,
   input  dds_pkg::wave_set_t waves,
   input  logic               symbol,
   input  dds_pkg::wave_sel_e wave_sel,
   input  dds_pkg::mod_sel_e  mod_sel,
   output dds_pkg::sample_t   wave_out,
   output dds_pkg::sample_t   mod_out
);

   dds_pkg::sample_t ask_wave;
   dds_pkg::sample_t fsk_wave;
   dds_pkg::sample_t bpsk_wave;
   dds_pkg::sample_t lfsr_wave;
   dds_pkg::sample_t wave_next;
   dds_pkg::sample_t mod_next;

   ////////////////////
   // modulated signals
   ////////////////////

   assign ask_wave  = symbol ? waves.sine : '0;              // on/off keying
   assign fsk_wave  = waves.sine;                            // frequency set by top
   assign bpsk_wave = symbol ? -waves.cosine : waves.cosine; // 180 degree flip
   assign lfsr_wave = symbol ? '0 : dds_pkg::LFSR_LOW_LEVEL;

   // waveform choice
   always_comb
   begin
      case (wave_sel)
         dds_pkg::WAVE_SINE:   wave_next = waves.sine;
         dds_pkg::WAVE_COSINE: wave_next = waves.cosine;
         dds_pkg::WAVE_SAW:    wave_next = waves.saw;
         dds_pkg::WAVE_SQUARE: wave_next = waves.square;
         default:              wave_next = '0;
      endcase
   end

   // modulation choice
   always_comb
   begin
      case (mod_sel)
         dds_pkg::MOD_ASK:  mod_next = ask_wave;
         dds_pkg::MOD_FSK:  mod_next = fsk_wave;
         dds_pkg::MOD_BPSK: mod_next = bpsk_wave;
         dds_pkg::MOD_LFSR: mod_next = lfsr_wave;
         default:           mod_next = '0;
      endcase
   end

   ////////////////////
   // output register
   ////////////////////

   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
      begin
         wave_out <= '0;
         mod_out  <= '0;
      end
      else
      begin
         wave_out <= wave_next;
         mod_out  <= mod_next;
      end
   end

endmodule

/* design/lfsr_symbol_gen.sv */
module lfsr_symbol_gen #(
   parameter int TICK_DIVIDE = 25_000_000   // clocks per LFSR step
) (
   input  logic CLK_25MHZ,
   input  logic reset_from_key,
   output logic symbol
);

   localparam int COUNT_WIDTH = (TICK_DIVIDE > 1) ? $clog2(TICK_DIVIDE) : 1;
   localparam logic [COUNT_WIDTH-1:0] COUNT_LAST = COUNT_WIDTH'(TICK_DIVIDE - 1);

   logic [COUNT_WIDTH-1:0] tick_count;
   logic tick;
   logic [dds_pkg::LFSR_WIDTH-1:0] lfsr;
   logic feedback;

   ////////////////////
   // tick divider
   ////////////////////

   // enable pulse instead of a slow clock
   assign tick = (tick_count == COUNT_LAST);

   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
      begin
         tick_count <= '0;
      end
      else if (tick)
      begin
         tick_count <= '0;   // wrap
      end
      else
      begin
         tick_count <= tick_count + 1'b1;
      end
   end

   ////////////////////
   // 5-bit LFSR
   ////////////////////

   assign feedback = lfsr[0] ^ lfsr[2];   // x^5+x^3+1, period 31

   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
      begin
         lfsr <= dds_pkg::LFSR_SEED;
      end
      else if (tick)
      begin
         // shift toward bit 0, feedback into bit 4
         lfsr <= {feedback, lfsr[dds_pkg::LFSR_WIDTH-1:1]};
      end
   end

   assign symbol = lfsr[0];   // straight from the register

endmodule

/* design/dds_waveform_gen.sv */
module dds_waveform_gen (
   input  logic               CLK_25MHZ,
   input  logic               reset_from_key,
   input  dds_pkg::phase_t    tuning,         // phase step per clock
   output dds_pkg::wave_set_t waves
);

   localparam string TABLE_FILE = "design/sine_table.hex";

   // one full sine period, signed 12-bit
   dds_pkg::sample_t sine_rom [0:dds_pkg::TABLE_DEPTH-1];

   dds_pkg::phase_t phase;
   logic [dds_pkg::TABLE_ADDR_WIDTH-1:0] sine_addr;
   logic [dds_pkg::TABLE_ADDR_WIDTH-1:0] cos_addr;
   logic [dds_pkg::SAMPLE_WIDTH-1:0] saw_bits;
   logic phase_msb;

   initial
   begin
      $readmemh(TABLE_FILE, sine_rom);
   end

   ////////////////////
   // phase accumulator
   ////////////////////

   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
      begin
         phase <= '0;
      end
      else
      begin
         phase <= phase + tuning;   // wraps at 2^32
      end
   end

   ////////////////////
   // table addressing
   ////////////////////

   // top phase bits index the table
   assign sine_addr = phase[dds_pkg::PHASE_WIDTH-1 -: dds_pkg::TABLE_ADDR_WIDTH];

   // quarter period ahead, wraps in 6 bits
   assign cos_addr = sine_addr + dds_pkg::QUARTER_OFFSET;

   assign saw_bits  = phase[dds_pkg::PHASE_WIDTH-1 -: dds_pkg::SAMPLE_WIDTH];
   assign phase_msb = phase[dds_pkg::PHASE_WIDTH-1];

   ////////////////////
   // waveform register
   ////////////////////

   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
      begin
         waves <= '0;
      end
      else
      begin
         waves.sine   <= sine_rom[sine_addr];
         waves.cosine <= sine_rom[cos_addr];
         waves.saw    <= dds_pkg::sample_t'(saw_bits);   // ramp read as signed
         if (phase_msb)
         begin
            waves.square <= -dds_pkg::SQUARE_HIGH;     // second half period
         end
         else
         begin
            waves.square <= dds_pkg::SQUARE_HIGH;
         end
      end
   end

endmodule

/* design/dds_pkg.sv */
package dds_pkg;

   ////////////////////
   // sample and phase widths
   ////////////////////

   localparam int SAMPLE_WIDTH = 12;
   typedef logic signed [SAMPLE_WIDTH-1:0] sample_t;   // one signed waveform sample

   localparam int PHASE_WIDTH = 32;
   typedef logic [PHASE_WIDTH-1:0] phase_t;            // accumulator and tuning word

   // sine table geometry
   localparam int TABLE_ADDR_WIDTH = 6;
   localparam int TABLE_DEPTH = 1 << TABLE_ADDR_WIDTH; // 64 entries per period
   localparam logic [TABLE_ADDR_WIDTH-1:0] QUARTER_OFFSET = 6'd16; // sine to cosine

   ////////////////////
   // levels and defaults
   ////////////////////

   localparam phase_t DEFAULT_TUNING = 32'd258;        // tuning outside FSK

   // square swings between +2047 and -2047
   localparam sample_t SQUARE_HIGH = 12'sd2047;

   localparam sample_t LFSR_LOW_LEVEL = 12'h800;       // most negative sample

   // 5-bit LFSR, x^5+x^3+1
   localparam int LFSR_WIDTH = 5;
   localparam logic [LFSR_WIDTH-1:0] LFSR_SEED = 5'b00001;

   ////////////////////
   // selectors
   ////////////////////

   typedef enum logic [1:0] {
      WAVE_SINE   = 2'b00,
      WAVE_COSINE = 2'b01,
      WAVE_SAW    = 2'b10,
      WAVE_SQUARE = 2'b11
   } wave_sel_e;

   typedef enum logic [1:0] {
      MOD_ASK  = 2'b00,
      MOD_FSK  = 2'b01,
      MOD_BPSK = 2'b10,
      MOD_LFSR = 2'b11
   } mod_sel_e;

   // the four generator outputs, 48 bits
   typedef struct packed {
      sample_t sine;
      sample_t cosine;
      sample_t saw;
      sample_t square;
   } wave_set_t;

endpackage
